// File: filelist.f
+incdir+.
hawk_tbl_pkg.sv
hawk_xlat_pkg.sv
hawk_tbl_mem.sv
hawk_pgrd_mngr.sv
hawk_upd_fifo.sv
hawk_pgwr_mngr.sv
hawk_top.sv
tb_hawk.sv

// File: hawk_macros.svh
// sizes shared by the page translation front end
// widths, table sizes, address bases and update buffer depth
`ifndef HAWK_MACROS_SVH
`define HAWK_MACROS_SVH

// page numbers, hppa and ppa alike
`define HAWK_PAGE_WIDTH   20

// one table word, ATT or free-list entry
`define HAWK_WORD_WIDTH   64

// ATT entries use ids 1..16
`define HAWK_ATT_ENTRIES  16

// free-list entries use ids 1..8, id 0 is the null link
`define HAWK_TOL_ENTRIES  8

// table index width, a region select bit rides above it
`define HAWK_IDX_WIDTH    5

// first host page covered by the ATT
`define HAWK_HPPA_BASE    20'h80000

// first physical page handed out by the free list
`define HAWK_PPA_BASE     20'h00100

// entries in the update buffer between read and write managers
`define HAWK_UPD_DEPTH    4

`endif

// File: hawk_pgrd_mngr.sv
// page read manager: lookup FSM over the ATT and the free list
// answers translations and queues table updates for the write manager
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module hawk_pgrd_mngr (
  input  wire                            clk_i,
  input  wire                            rst_ni,
  input  wire                            lookup,     // pulse, only while ready
  input  wire  [`HAWK_PAGE_WIDTH-1:0]    hppa,
  input  wire                            rd_valid,
  input  wire                            rd_err,
  input  wire  hawk_tbl_pkg::tbl_word_u  rd_data,
  input  wire  [`HAWK_IDX_WIDTH-1:0]     tol_head,   // free-list head from write manager
  input  wire                            full,
  input  wire                            empty,
  output logic                           rd_req,
  output logic [`HAWK_IDX_WIDTH:0]       rd_idx,
  output logic                           push,
  output hawk_xlat_pkg::upd_pkt_t        upd_pkt,
  output logic                           ready,
  output logic                           trnsl_valid,
  output logic                           trnsl_allow,
  output hawk_tbl_pkg::page_sts_e        trnsl_sts,
  output logic [`HAWK_PAGE_WIDTH-1:0]    trnsl_ppa,
  output logic                           bus_error
);

  hawk_xlat_pkg::pgrd_state_e    p_state, n_state;
  logic [`HAWK_IDX_WIDTH-1:0]    p_att_id, n_att_id;
  hawk_tbl_pkg::tbl_word_u       p_rdata, n_rdata;  // last table word read
  logic [`HAWK_PAGE_WIDTH-1:0]   page_ofs;
  logic [`HAWK_IDX_WIDTH-1:0]    lkup_id;

  logic                          n_rd_req, n_push, n_valid, n_allow;
  logic [`HAWK_IDX_WIDTH:0]      n_rd_idx;
  hawk_xlat_pkg::upd_pkt_t       n_upd_pkt;
  hawk_tbl_pkg::page_sts_e       n_sts;
  logic [`HAWK_PAGE_WIDTH-1:0]   n_ppa;

  // entry ids start at 1, anything that does not fit becomes id 0
  // so the memory flags it as an error
  assign page_ofs = hppa - `HAWK_HPPA_BASE + `HAWK_PAGE_WIDTH'(1);
  assign lkup_id  = (|page_ofs[`HAWK_PAGE_WIDTH-1:`HAWK_IDX_WIDTH]) ? '0
                                                                      : page_ofs[`HAWK_IDX_WIDTH-1:0];

  always_comb begin
    n_state   = p_state;  // stay unless told otherwise
    n_att_id  = p_att_id;
    n_rdata   = p_rdata;
    n_rd_req  = 1'b0;     // strobes are one cycle
    n_rd_idx  = rd_idx;
    n_push    = 1'b0;
    n_upd_pkt = upd_pkt;
    n_valid   = 1'b0;
    n_allow   = trnsl_allow;  // response fields hold until the next answer
    n_sts     = trnsl_sts;
    n_ppa     = trnsl_ppa;
    case (p_state)
      hawk_xlat_pkg::IDLE: begin
        if (lookup) begin
          n_att_id = lkup_id;
          n_state  = hawk_xlat_pkg::WAIT_EMPTY;
        end
      end
      hawk_xlat_pkg::WAIT_EMPTY: begin
        // a queued update may touch this entry or the head
        if (empty) n_state = hawk_xlat_pkg::LOOKUP_ATT;
      end
      hawk_xlat_pkg::LOOKUP_ATT: begin
        n_rd_req = 1'b1;
        n_rd_idx = {1'b0, p_att_id};  // ATT region
        n_state  = hawk_xlat_pkg::WAIT_ATT;
      end
      hawk_xlat_pkg::WAIT_ATT: begin
        if (rd_valid) begin
          n_rdata = rd_data;
          n_state = rd_err ? hawk_xlat_pkg::BUS_ERROR : hawk_xlat_pkg::DECODE;
        end
      end
      hawk_xlat_pkg::DECODE: begin
        case (p_rdata.att.sts)
          hawk_tbl_pkg::UNCOMP, hawk_tbl_pkg::INCOMP: begin  // hit
            n_valid = 1'b1;
            n_allow = 1'b1;
            n_sts   = p_rdata.att.sts;
            n_ppa   = p_rdata.att.ppa;
            n_state = hawk_xlat_pkg::IDLE;
          end
          hawk_tbl_pkg::COMP: begin  // no decompression path, refuse
            n_valid = 1'b1;
            n_allow = 1'b0;
            n_sts   = hawk_tbl_pkg::COMP;
            n_state = hawk_xlat_pkg::IDLE;
          end
          default: n_state = hawk_xlat_pkg::POP_FREE;  // DALLOC
        endcase
      end
      hawk_xlat_pkg::POP_FREE: begin
        if (tol_head != '0) begin
          n_rd_req = 1'b1;
          n_rd_idx = {1'b1, tol_head};  // free-list region
          n_state  = hawk_xlat_pkg::WAIT_LST;
        end else begin
          n_valid = 1'b1;  // list exhausted
          n_allow = 1'b0;
          n_sts   = hawk_tbl_pkg::DALLOC;
          n_state = hawk_xlat_pkg::IDLE;
        end
      end
      hawk_xlat_pkg::WAIT_LST: begin
        if (rd_valid) begin
          n_rdata = rd_data;
          n_state = rd_err ? hawk_xlat_pkg::BUS_ERROR : hawk_xlat_pkg::ALLOCATE;
        end
      end
      hawk_xlat_pkg::ALLOCATE: begin
        if (!full) begin  // hold here while the buffer is full
          n_push             = 1'b1;
          n_upd_pkt.att_id   = p_att_id;
          n_upd_pkt.ppa      = p_rdata.lst.ppa;
          n_upd_pkt.new_head = p_rdata.lst.nxt;
          n_valid            = 1'b1;
          n_allow            = 1'b1;
          n_sts              = hawk_tbl_pkg::UNCOMP;
          n_ppa              = p_rdata.lst.ppa;
          n_state            = hawk_xlat_pkg::IDLE;
        end
      end
      default: n_state = hawk_xlat_pkg::BUS_ERROR;  // stuck until reset
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      p_state     <= hawk_xlat_pkg::IDLE;
      rd_req      <= 1'b0;
      push        <= 1'b0;
      trnsl_valid <= 1'b0;
      trnsl_allow <= 1'b0;
      trnsl_sts   <= hawk_tbl_pkg::DALLOC;
      trnsl_ppa   <= '0;
    end else begin
      p_state     <= n_state;
      rd_req      <= n_rd_req;
      push        <= n_push;
      trnsl_valid <= n_valid;
      trnsl_allow <= n_allow;
      trnsl_sts   <= n_sts;
      trnsl_ppa   <= n_ppa;
    end
  end

  // payload only
  always_ff @(posedge clk_i) begin
    p_att_id <= n_att_id;
    p_rdata  <= n_rdata;
    rd_idx   <= n_rd_idx;
    upd_pkt  <= n_upd_pkt;
  end

  assign ready     = (p_state == hawk_xlat_pkg::IDLE);
  assign bus_error = (p_state == hawk_xlat_pkg::BUS_ERROR);

  // table memory answers exactly one cycle after a request
  a_rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_valid |-> $past(rd_req))
    else $error("read response without a request");

  a_lookup_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup |-> ready)
    else $error("lookup while busy");

endmodule

`default_nettype wire

// File: hawk_pgwr_mngr.sv
// page write manager: drains table updates into the ATT
// and owns the free-list head register
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module hawk_pgwr_mngr (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          empty,
  input  wire hawk_xlat_pkg::upd_pkt_t pop_pkt,
  output logic                         pop,
  output logic                         wr_en,
  output logic [`HAWK_IDX_WIDTH:0]     wr_idx,
  output hawk_tbl_pkg::tbl_word_u      wr_data,
  output logic [`HAWK_IDX_WIDTH-1:0]   tol_head
);

  hawk_xlat_pkg::upd_pkt_t pkt_q;  // packet being written

  // one packet per two cycles, pop then write
  assign pop = !empty && !wr_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) pkt_q <= pop_pkt;
  end

  // head moves in the same cycle the ATT entry lands,
  // reset value points at the first chained entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tol_head <= `HAWK_IDX_WIDTH'(1);
    end else if (wr_en) begin
      tol_head <= pkt_q.new_head;  // 0 once the list runs dry
    end
  end

  assign wr_idx = {1'b0, pkt_q.att_id};  // always the ATT region

  // new ATT word, page now backed and uncompressed
  always_comb begin
    wr_data         = '0;
    wr_data.att.sts = hawk_tbl_pkg::UNCOMP;
    wr_data.att.ppa = pkt_q.ppa;
  end

  // read manager never queues a lookup that missed the table
  a_att_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> (pkt_q.att_id != '0))
    else $error("update packet with null ATT id");

endmodule

`default_nettype wire

// File: hawk_tbl_mem.sv
// table memory: ATT and free-list regions, one read and one write port
// reset loads an all-deallocated ATT and a chained free list
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module hawk_tbl_mem (
  input  wire                           clk_i,
  input  wire                           rst_ni,
  input  wire                           rd_req,
  input  wire  [`HAWK_IDX_WIDTH:0]      rd_idx,   // msb selects the free-list region
  input  wire                           wr_en,
  input  wire  [`HAWK_IDX_WIDTH:0]      wr_idx,
  input  wire  hawk_tbl_pkg::tbl_word_u wr_data,
  output logic                          rd_valid,
  output logic                          rd_err,
  output hawk_tbl_pkg::tbl_word_u       rd_data
);

  hawk_tbl_pkg::tbl_word_u att_mem [1:`HAWK_ATT_ENTRIES];
  hawk_tbl_pkg::tbl_word_u tol_mem [1:`HAWK_TOL_ENTRIES];

  logic                    rd_ok, wr_ok;
  hawk_tbl_pkg::tbl_word_u rd_word;

  // id 0 is null in both regions, upper bound depends on the region
  assign rd_ok = (rd_idx[`HAWK_IDX_WIDTH-1:0] != '0) &&
                 (rd_idx[`HAWK_IDX_WIDTH] ? (rd_idx[`HAWK_IDX_WIDTH-1:0] <= `HAWK_TOL_ENTRIES)
                                          : (rd_idx[`HAWK_IDX_WIDTH-1:0] <= `HAWK_ATT_ENTRIES));
  assign wr_ok = (wr_idx[`HAWK_IDX_WIDTH-1:0] != '0) &&
                 (wr_idx[`HAWK_IDX_WIDTH] ? (wr_idx[`HAWK_IDX_WIDTH-1:0] <= `HAWK_TOL_ENTRIES)
                                          : (wr_idx[`HAWK_IDX_WIDTH-1:0] <= `HAWK_ATT_ENTRIES));

  always_comb begin
    rd_word = '0;
    if (rd_ok) begin
      rd_word = rd_idx[`HAWK_IDX_WIDTH] ? tol_mem[rd_idx[`HAWK_IDX_WIDTH-1:0]]
                                        : att_mem[rd_idx[`HAWK_IDX_WIDTH-1:0]];
    end
  end

  // table contents, loaded at reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 1; k <= `HAWK_ATT_ENTRIES; k++) begin
        att_mem[k] <= '0;  // all-zero word reads as DALLOC
      end
      for (int k = 1; k <= `HAWK_TOL_ENTRIES; k++) begin
        tol_mem[k]         <= '0;
        tol_mem[k].lst.ppa <= `HAWK_PPA_BASE + `HAWK_PAGE_WIDTH'(k - 1);
        tol_mem[k].lst.nxt <= (k == `HAWK_TOL_ENTRIES) ? '0 : `HAWK_IDX_WIDTH'(k + 1);
      end
    end else if (wr_en && wr_ok) begin
      if (wr_idx[`HAWK_IDX_WIDTH]) tol_mem[wr_idx[`HAWK_IDX_WIDTH-1:0]] <= wr_data;
      else                         att_mem[wr_idx[`HAWK_IDX_WIDTH-1:0]] <= wr_data;
    end
  end

  // fixed one cycle read response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid <= 1'b0;
      rd_err   <= 1'b0;
    end else begin
      rd_valid <= rd_req;
      rd_err   <= rd_req && !rd_ok;  // null or beyond the region
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) rd_data <= rd_word;
  end

  // the write manager only ever targets real entries
  a_wr_range: assert property (@(posedge clk_i) disable iff (!rst_ni) wr_en |-> wr_ok)
    else $error("table write to out-of-range index %0h", wr_idx);

endmodule

`default_nettype wire

// File: hawk_tbl_pkg.sv
// table side types: page status and the two views of a table word
`default_nettype none

`include "hawk_macros.svh"

package hawk_tbl_pkg;

  // page status as stored in an ATT entry
  typedef enum logic [1:0] {
    DALLOC = 2'd0,  // not backed, all entries start here
    UNCOMP = 2'd1,  // backed by an uncompressed page
    INCOMP = 2'd2,  // incompressible, still directly mapped
    COMP   = 2'd3   // compressed, not served here
  } page_sts_e;

  // ATT entry layout, status in the top bits
  typedef struct packed {
    page_sts_e                                      sts;
    logic [`HAWK_PAGE_WIDTH-1:0]                    ppa;
    logic [`HAWK_WORD_WIDTH-`HAWK_PAGE_WIDTH-3:0]   pad;
  } att_view_t;

  // free-list entry layout, link to the next free entry on top
  typedef struct packed {
    logic [`HAWK_IDX_WIDTH-1:0]                                   nxt;  // 0 ends the list
    logic [`HAWK_PAGE_WIDTH-1:0]                                  ppa;
    logic [`HAWK_WORD_WIDTH-`HAWK_PAGE_WIDTH-`HAWK_IDX_WIDTH-1:0] pad;
  } lst_view_t;

  // one stored word, its meaning depends on which region it came from
  typedef union packed {
    att_view_t att;
    lst_view_t lst;
  } tbl_word_u;

endpackage

`default_nettype wire

// File: hawk_top.sv
// translation front end top: read manager, update FIFO,
// write manager and the shared table memory
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module hawk_top (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          lookup,
  input  wire [`HAWK_PAGE_WIDTH-1:0]   hppa,
  output logic                         ready,
  output logic                         trnsl_valid,
  output logic                         trnsl_allow,
  output hawk_tbl_pkg::page_sts_e      trnsl_sts,
  output logic [`HAWK_PAGE_WIDTH-1:0]  trnsl_ppa,
  output logic                         bus_error
);

  // table read path
  logic                        rd_req, rd_valid, rd_err;
  logic [`HAWK_IDX_WIDTH:0]    rd_idx;
  hawk_tbl_pkg::tbl_word_u     rd_data;
  // table write path
  logic                        wr_en;
  logic [`HAWK_IDX_WIDTH:0]    wr_idx;
  hawk_tbl_pkg::tbl_word_u     wr_data;
  // update buffer
  logic                        push, pop, full, empty;
  hawk_xlat_pkg::upd_pkt_t     upd_pkt, pop_pkt;
  logic [`HAWK_IDX_WIDTH-1:0]  tol_head;

  hawk_pgrd_mngr i_pgrd_mngr (
    .clk_i, .rst_ni, .lookup, .hppa, .rd_valid, .rd_err, .rd_data, .tol_head,
    .full, .empty, .rd_req, .rd_idx, .push, .upd_pkt, .ready, .trnsl_valid,
    .trnsl_allow, .trnsl_sts, .trnsl_ppa, .bus_error
  );

  hawk_upd_fifo #(.DEPTH(`HAWK_UPD_DEPTH)) i_upd_fifo (
    .clk_i, .rst_ni, .push, .push_pkt(upd_pkt), .pop, .pop_pkt, .full, .empty
  );

  hawk_pgwr_mngr i_pgwr_mngr (
    .clk_i, .rst_ni, .empty, .pop_pkt, .pop, .wr_en, .wr_idx, .wr_data, .tol_head
  );

  hawk_tbl_mem i_tbl_mem (
    .clk_i, .rst_ni, .rd_req, .rd_idx, .wr_en, .wr_idx, .wr_data,
    .rd_valid, .rd_err, .rd_data
  );

endmodule

`default_nettype wire

// File: hawk_upd_fifo.sv
// synchronous FIFO for table update packets, show-ahead read
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module hawk_upd_fifo #(
  parameter int DEPTH = `HAWK_UPD_DEPTH
) (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          push,
  input  wire hawk_xlat_pkg::upd_pkt_t push_pkt,
  input  wire                          pop,
  output hawk_xlat_pkg::upd_pkt_t      pop_pkt,   // head entry, valid while !empty
  output logic                         full,
  output logic                         empty
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  hawk_xlat_pkg::upd_pkt_t mem [DEPTH];
  logic [PW-1:0]           wr_ptr, rd_ptr;
  logic [CW-1:0]           count;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wraps for any depth
      if (pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= push_pkt;
  end

  assign pop_pkt = mem[rd_ptr];
  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);

  // producer honors full, consumer honors empty
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push && full))
    else $error("push into full update FIFO");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop && empty))
    else $error("pop from empty update FIFO");

endmodule

`default_nettype wire

// File: hawk_xlat_pkg.sv
// translation side types: update packet and read manager FSM states
`default_nettype none

`include "hawk_macros.svh"

package hawk_xlat_pkg;

  // table update handed from read manager to write manager
  typedef struct packed {
    logic [`HAWK_IDX_WIDTH-1:0]  att_id;    // ATT entry to mark UNCOMP
    logic [`HAWK_PAGE_WIDTH-1:0] ppa;       // page taken from the free list
    logic [`HAWK_IDX_WIDTH-1:0]  new_head;  // free-list head after the pop
  } upd_pkt_t;

  // lookup FSM states
  typedef enum logic [3:0] {
    IDLE       = 4'd0,
    WAIT_EMPTY = 4'd1,  // let pending updates land first
    LOOKUP_ATT = 4'd2,
    WAIT_ATT   = 4'd3,
    DECODE     = 4'd4,
    POP_FREE   = 4'd5,
    WAIT_LST   = 4'd6,
    ALLOCATE   = 4'd7,
    BUS_ERROR  = 4'd8   // sticky until reset
  } pgrd_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_hawk -o sim_hawk

out=$(./obj_dir/sim_hawk 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Verification passed$"; then
  exit 0
else
  exit 1
fi

// File: tb_hawk.sv
// testbench for the page translation front end
// clock, reset, watchdog, value check and directed lookup tests
`timescale 1ns/1ns
`default_nettype none

`include "hawk_macros.svh"

module tb_hawk;

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;  // 200 cycles per test

  logic                          clk_i;
  logic                          rst_ni;
  logic                          lookup;
  logic [`HAWK_PAGE_WIDTH-1:0]   hppa;
  logic                          ready;
  logic                          trnsl_valid;
  logic                          trnsl_allow;
  hawk_tbl_pkg::page_sts_e       trnsl_sts;
  logic [`HAWK_PAGE_WIDTH-1:0]   trnsl_ppa;
  logic                          bus_error;

  // reference model of the tables
  logic                          alloc_map [1:`HAWK_ATT_ENTRIES];  // page already backed
  logic [`HAWK_PAGE_WIDTH-1:0]   ppa_map   [1:`HAWK_ATT_ENTRIES];
  int                            next_free;  // free-list id handed out next
  string                         test_name;
  int                            seed;

  hawk_top i_dut (
    .clk_i, .rst_ni, .lookup, .hppa, .ready, .trnsl_valid, .trnsl_allow,
    .trnsl_sts, .trnsl_ppa, .bus_error
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ends a run that hangs
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("error test=%s %s expected=%0h actual=%0h", test_name, what, exp, act);
      $display("Verification failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic clear_model();
    for (int k = 1; k <= `HAWK_ATT_ENTRIES; k++) begin
      alloc_map[k] = 1'b0;
      ppa_map[k]   = '0;
    end
    next_free = 1;  // list starts at entry 1
  endtask

  // async reset held for two cycles, released on a falling edge
  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    lookup = 1'b0;
    hppa   = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    clear_model();
  endtask

  // expected answer from the allocation rules, in-range pages only
  task automatic predict(input logic [`HAWK_PAGE_WIDTH-1:0] page, output logic allow,
                         output hawk_tbl_pkg::page_sts_e sts,
                         output logic [`HAWK_PAGE_WIDTH-1:0] ppa);
    int id;
    id    = int'(page - `HAWK_HPPA_BASE) + 1;
    allow = 1'b1;
    sts   = hawk_tbl_pkg::UNCOMP;
    ppa   = '0;
    if (alloc_map[id]) begin
      ppa = ppa_map[id];  // hit
    end else if (next_free <= `HAWK_TOL_ENTRIES) begin
      ppa           = `HAWK_PPA_BASE + `HAWK_PAGE_WIDTH'(next_free - 1);
      alloc_map[id] = 1'b1;
      ppa_map[id]   = ppa;
      next_free++;
    end else begin
      allow = 1'b0;  // free list exhausted
      sts   = hawk_tbl_pkg::DALLOC;
    end
  endtask

  task automatic start_lookup(input logic [`HAWK_PAGE_WIDTH-1:0] page);
    @(negedge clk_i);
    while (!ready) @(negedge clk_i);
    lookup = 1'b1;
    hppa   = page;
    @(negedge clk_i);
    lookup = 1'b0;
  endtask

  task automatic lookup_and_check(input logic [`HAWK_PAGE_WIDTH-1:0] page);
    logic                        exp_allow;
    hawk_tbl_pkg::page_sts_e     exp_sts;
    logic [`HAWK_PAGE_WIDTH-1:0] exp_ppa;
    predict(page, exp_allow, exp_sts, exp_ppa);
    start_lookup(page);
    while (!trnsl_valid) @(negedge clk_i);  // response pulse, sampled mid-cycle
    check_val("allow", 32'(exp_allow), 32'(trnsl_allow));
    check_val("sts", 32'(exp_sts), 32'(trnsl_sts));
    if (exp_allow) check_val("ppa", 32'(exp_ppa), 32'(trnsl_ppa));
  endtask

  task automatic test_reset();
    test_name = "reset";
    apply_reset();
    check_val("ready", 32'd1, 32'(ready));
    check_val("trnsl_valid", 32'd0, 32'(trnsl_valid));
    check_val("bus_error", 32'd0, 32'(bus_error));
  endtask

  task automatic test_first_alloc();
    test_name = "first_alloc";
    apply_reset();
    lookup_and_check(`HAWK_HPPA_BASE + 20'd3);  // takes PPA_BASE
  endtask

  task automatic test_repeat_hit();
    test_name = "repeat_hit";
    apply_reset();
    lookup_and_check(`HAWK_HPPA_BASE + 20'd3);
    lookup_and_check(`HAWK_HPPA_BASE + 20'd3);  // same ppa again
  endtask

  task automatic test_order_exhaust();
    logic                        used [0:`HAWK_ATT_ENTRIES-1];
    logic [`HAWK_PAGE_WIDTH-1:0] pages [0:`HAWK_TOL_ENTRIES];
    int                          ofs;
    test_name = "order_exhaust";
    apply_reset();
    for (int k = 0; k < `HAWK_ATT_ENTRIES; k++) used[k] = 1'b0;
    // eight allocations plus one page that finds the list empty
    for (int n = 0; n <= `HAWK_TOL_ENTRIES; n++) begin
      ofs = int'($unsigned($random(seed)) % `HAWK_ATT_ENTRIES);
      while (used[ofs]) ofs = int'($unsigned($random(seed)) % `HAWK_ATT_ENTRIES);
      used[ofs] = 1'b1;
      pages[n]  = `HAWK_HPPA_BASE + `HAWK_PAGE_WIDTH'(ofs);
      lookup_and_check(pages[n]);
    end
    for (int n = 0; n < `HAWK_TOL_ENTRIES; n++) begin
      lookup_and_check(pages[n]);  // earlier pages keep their own ppa
    end
  endtask

  task automatic test_bus_error();
    test_name = "bus_error";
    apply_reset();
    start_lookup(`HAWK_HPPA_BASE + 20'd40);  // beyond the ATT
    while (!bus_error) begin
      check_val("trnsl_valid", 32'd0, 32'(trnsl_valid));
      @(negedge clk_i);
    end
    repeat (20) begin
      @(negedge clk_i);
      check_val("bus_error", 32'd1, 32'(bus_error));  // sticky
      check_val("ready", 32'd0, 32'(ready));
      check_val("trnsl_valid", 32'd0, 32'(trnsl_valid));
    end
  endtask

  initial begin
    rst_ni     = 1'b0;
    lookup     = 1'b0;
    hppa       = '0;
    seed       = 77;
    test_name  = "init";
    clear_model();
    test_reset();
    test_first_alloc();
    test_repeat_hit();
    test_order_exhaust();
    test_bus_error();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
